/* project.f */
verilog/open_fifo_pkg.sv
verilog/open_fifo_bank_if.sv
verilog/open_fifo_bank.sv
verilog/open_fifo_2w2r.sv
verilog/open_fifo_top.sv
verification/open_fifo_chk.sv
verification/open_fifo_tb.sv

/* verification/open_fifo_chk.sv */
`timescale 1ns/1ns

module open_fifo_chk
  import open_fifo_pkg::*;
(
  input logic      clk,
  input logic      arst_n,
  input port_req_e push_req,
  input port_req_e pop_req,
  input logic      push0,
  input logic      pop0,
  input logic      full,
  input logic      one_left_to_full,
  input logic      empty,
  input logic      one_left_to_empty
);

  // Failed assertions so far
  int fail_count = 0;

  // Port 1 never acts alone
  a_push_order: assert property (@(posedge clk) disable iff (!arst_n)
    push_req != REQ_BAD)
    else begin
      $error("push on port 1 without port 0");
      fail_count++;
    end

  a_pop_order: assert property (@(posedge clk) disable iff (!arst_n)
    pop_req != REQ_BAD)
    else begin
      $error("pop on port 1 without port 0");
      fail_count++;
    end

  a_push_full: assert property (@(posedge clk) disable iff (!arst_n)
    full |-> !push0)
    else begin
      $error("push while the FIFO is full");
      fail_count++;
    end

  a_push_two_near_full: assert property (@(posedge clk) disable iff (!arst_n)
    one_left_to_full |-> push_req != REQ_BOTH)
    else begin
      $error("double push with one slot left");
      fail_count++;
    end

  a_pop_empty: assert property (@(posedge clk) disable iff (!arst_n)
    empty |-> !pop0)
    else begin
      $error("pop while the FIFO is empty");
      fail_count++;
    end

  a_pop_two_near_empty: assert property (@(posedge clk) disable iff (!arst_n)
    one_left_to_empty |-> pop_req != REQ_BOTH)
    else begin
      $error("double pop with one entry left");
      fail_count++;
    end

endmodule

/* verification/open_fifo_tb.sv */
`timescale 1ns/1ns

module open_fifo_tb
  import open_fifo_pkg::*;
;

  localparam int data_width = 32;
  localparam int num_cycles = 800;
  localparam int drain_limit = 16;

  typedef struct packed {
    logic                      full;
    logic                      one_left_to_full;
    logic                      empty;
    logic                      one_left_to_empty;
    logic [fifo_depth-1:0]     valid;
    logic [fifo_ptr_width-1:0] oldest;
  } status_t;

  logic                      clk = 1'b0;
  logic                      arst_n;
  logic                      push0;
  logic                      push1;
  logic [data_width-1:0]     in_data0;
  logic [data_width-1:0]     in_data1;
  logic                      pop0;
  logic                      pop1;
  logic [data_width-1:0]     out_data0;
  logic [data_width-1:0]     out_data1;
  logic                      full;
  logic                      one_left_to_full;
  logic                      empty;
  logic                      one_left_to_empty;
  logic [data_width-1:0]     entry [fifo_depth];
  logic [fifo_depth-1:0]     entry_valid;
  logic [fifo_ptr_width-1:0] oldest_ptr;
  logic                      checking;

  // Reference model with the oldest item at the front
  logic [data_width-1:0] q_data [$];
  int                    q_idx [$];
  int                    wr_slot [2];
  int                    rd_slot [2];
  int                    push_swap_m;
  int                    pop_swap_m;

  always #2 clk = ~clk;

  open_fifo_top #(.data_width(data_width)) i_dut (
    .clk              (clk),
    .arst_n           (arst_n),
    .push0            (push0),
    .in_data0         (in_data0),
    .push1            (push1),
    .in_data1         (in_data1),
    .pop0             (pop0),
    .pop1             (pop1),
    .out_data0        (out_data0),
    .out_data1        (out_data1),
    .full             (full),
    .one_left_to_full (one_left_to_full),
    .empty            (empty),
    .one_left_to_empty(one_left_to_empty),
    .entry            (entry),
    .entry_valid      (entry_valid),
    .oldest_ptr       (oldest_ptr)
  );

  bind open_fifo_2w2r open_fifo_chk u_chk (
    .clk              (clk),
    .arst_n           (arst_n),
    .push_req         (push_req),
    .pop_req          (pop_req),
    .push0            (push0),
    .pop0             (pop0),
    .full             (full),
    .one_left_to_full (one_left_to_full),
    .empty            (empty),
    .one_left_to_empty(one_left_to_empty)
  );

  task automatic check(input logic [63:0] actual, input logic [63:0] expected,
                       input string what);
    if (actual !== expected) begin
      $display("CHECK FAILED at %0t ns: %s is %0h, expected %0h", $time, what, actual,
               expected);
      $display("tests failed");
      $fatal(1, "output mismatch");
    end
  endtask

  // An assertion failure in the bound checker ends the run
  always @(i_dut.u_fifo.u_chk.fail_count) begin
    if (i_dut.u_fifo.u_chk.fail_count != 0) begin
      $display("The FIFO checker saw an illegal request at %0t ns", $time);
      $display("tests failed");
      $fatal(1, "assertion failure");
    end
  end

  // The swap flag picks the bank of port 0 and port 1 takes the other one
  task automatic apply_cycle(input logic p0, input logic p1, input logic [data_width-1:0] d0,
                             input logic [data_width-1:0] d1, input logic r0, input logic r1);
    int bank;
    if (r0) begin
      bank = pop_swap_m;
      rd_slot[bank] = (rd_slot[bank] + 1) % bank_depth;
      void'(q_data.pop_front());
      void'(q_idx.pop_front());
    end
    if (r1) begin
      bank = pop_swap_m ? 0 : 1;
      rd_slot[bank] = (rd_slot[bank] + 1) % bank_depth;
      void'(q_data.pop_front());
      void'(q_idx.pop_front());
    end
    if (p0) begin
      bank = push_swap_m;
      q_data.push_back(d0);
      q_idx.push_back(2 * wr_slot[bank] + bank);
      wr_slot[bank] = (wr_slot[bank] + 1) % bank_depth;
    end
    if (p1) begin
      bank = push_swap_m ? 0 : 1;
      q_data.push_back(d1);
      q_idx.push_back(2 * wr_slot[bank] + bank);
      wr_slot[bank] = (wr_slot[bank] + 1) % bank_depth;
    end
    if (p0 && !p1) begin
      push_swap_m = 1 - push_swap_m;
    end
    if (r0 && !r1) begin
      pop_swap_m = 1 - pop_swap_m;
    end
  endtask

  function automatic status_t expected_status();
    status_t s;
    int      cnt [2];
    s = '0;
    cnt[0] = 0;
    cnt[1] = 0;
    foreach (q_idx[i]) begin
      cnt[q_idx[i] % 2]++;
      s.valid[q_idx[i]] = 1'b1;
    end
    s.full              = (cnt[0] == bank_depth) && (cnt[1] == bank_depth);
    s.one_left_to_full  = (cnt[0] == bank_depth) != (cnt[1] == bank_depth);
    s.empty             = (cnt[0] == 0) && (cnt[1] == 0);
    s.one_left_to_empty = (cnt[0] == 0) != (cnt[1] == 0);
    s.oldest            = fifo_ptr_width'(2 * rd_slot[pop_swap_m] + pop_swap_m);
    return s;
  endfunction

  task automatic compare_outputs();
    status_t exp;
    exp = expected_status();
    check(full, exp.full, "full");
    check(one_left_to_full, exp.one_left_to_full, "one_left_to_full");
    check(empty, exp.empty, "empty");
    check(one_left_to_empty, exp.one_left_to_empty, "one_left_to_empty");
    check(entry_valid, exp.valid, "entry_valid");
    check(oldest_ptr, exp.oldest, "oldest_ptr");
    if (q_data.size() > 0) begin
      check(out_data0, q_data[0], "out_data0");
    end
    if (q_data.size() > 1) begin
      check(out_data1, q_data[1], "out_data1");
    end
    foreach (q_data[i]) begin
      check(entry[q_idx[i]], q_data[i], $sformatf("entry[%0d]", q_idx[i]));
    end
  endtask

  task automatic drive_cycle(input int n_push, input int n_pop);
    push0    = n_push > 0;
    push1    = n_push > 1;
    in_data0 = $urandom;
    in_data1 = $urandom;
    pop0     = n_pop > 0;
    pop1     = n_pop > 1;
  endtask

  // Inputs are sampled at the rising edge and outputs one step later
  always @(posedge clk) begin
    if (checking) begin
      apply_cycle(push0, push1, in_data0, in_data1, pop0, pop1);
      #1;
      compare_outputs();
    end
  end

  initial begin
    int  max_push;
    int  max_pop;
    int  drain_cycles;
    bit  fill;
    void'($urandom(77803));
    arst_n      = 1'b0;
    checking    = 1'b0;
    push_swap_m = 0;
    pop_swap_m  = 0;
    wr_slot     = '{0, 0};
    rd_slot     = '{0, 0};
    drive_cycle(0, 0);
    for (int i = 0; i < 16; i++) begin
      @(negedge clk);
    end
    arst_n = 1'b1;
    compare_outputs();
    checking = 1'b1;

    // Alternate fill-biased and drain-biased stretches
    for (int c = 0; c < num_cycles; c++) begin
      @(negedge clk);
      fill     = ((c / 40) % 2) == 0;
      max_push = fifo_depth - q_data.size();
      max_push = (max_push < 2) ? max_push : 2;
      max_pop  = (q_data.size() < 2) ? q_data.size() : 2;
      if (fill && max_pop > 1) begin
        max_pop = 1;
      end
      if (!fill && max_push > 1) begin
        max_push = 1;
      end
      drive_cycle($urandom_range(max_push, 0), $urandom_range(max_pop, 0));
    end

    @(negedge clk);
    drain_cycles = 0;
    while (q_data.size() > 0 && drain_cycles < drain_limit) begin
      drive_cycle(0, (q_data.size() > 1) ? 2 : 1);
      @(negedge clk);
      drain_cycles++;
    end
    drive_cycle(0, 0);
    @(negedge clk);

    if (q_data.size() != 0 || empty !== 1'b1) begin
      $display("Timeout: FIFO did not drain within %0d cycles", drain_limit);
      $display("tests failed");
      $fatal(1, "drain timeout");
    end else begin
      $display("all tests passed");
      $finish;
    end
  end

endmodule

/* verilog/open_fifo_2w2r.sv */
`timescale 1ns/1ns

module open_fifo_2w2r
  import open_fifo_pkg::*;
#(
  parameter int data_width = 32
) (
  input  logic                      clk,
  input  logic                      arst_n,
  // Write side
  input  logic                      push0,
  input  logic [data_width-1:0]     in_data0,
  input  logic                      push1,
  input  logic [data_width-1:0]     in_data1,
  // Read side
  input  logic                      pop0,
  input  logic                      pop1,
  output logic [data_width-1:0]     out_data0,
  output logic [data_width-1:0]     out_data1,
  // Status
  output logic                      full,
  output logic                      one_left_to_full,
  output logic                      empty,
  output logic                      one_left_to_empty,
  // Window
  output logic [data_width-1:0]     entry [fifo_depth],
  output logic [fifo_depth-1:0]     entry_valid,
  output logic [fifo_ptr_width-1:0] oldest_ptr
);

  port_req_e push_req;
  port_req_e pop_req;
  logic      push_swap;
  logic      pop_swap;

  open_fifo_bank_if #(.data_width(data_width)) even_if ();
  open_fifo_bank_if #(.data_width(data_width)) odd_if ();

  assign push_req = to_req(push0, push1);
  assign pop_req  = to_req(pop0, pop1);

  // A lone port 0 access leaves the other bank next in line
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      push_swap <= 1'b0;
    end else if (push_req == REQ_PORT0) begin
      push_swap <= !push_swap;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      pop_swap <= 1'b0;
    end else if (pop_req == REQ_PORT0) begin
      pop_swap <= !pop_swap;
    end
  end

  // Push routing
  assign even_if.push    = push_swap ? push1 : push0;
  assign even_if.in_data = push_swap ? in_data1 : in_data0;
  assign odd_if.push     = push_swap ? push0 : push1;
  assign odd_if.in_data  = push_swap ? in_data0 : in_data1;

  // Pop routing, port 0 always sees the oldest head
  assign even_if.pop = pop_swap ? pop1 : pop0;
  assign odd_if.pop  = pop_swap ? pop0 : pop1;
  assign out_data0   = pop_swap ? odd_if.out_data : even_if.out_data;
  assign out_data1   = pop_swap ? even_if.out_data : odd_if.out_data;

  open_fifo_bank #(.data_width(data_width)) u_even (
    .clk   (clk),
    .arst_n(arst_n),
    .bif   (even_if.bank)
  );

  open_fifo_bank #(.data_width(data_width)) u_odd (
    .clk   (clk),
    .arst_n(arst_n),
    .bif   (odd_if.bank)
  );

  assign full              = even_if.full && odd_if.full;
  assign one_left_to_full  = even_if.full ^ odd_if.full;
  assign empty             = even_if.empty && odd_if.empty;
  assign one_left_to_empty = even_if.empty ^ odd_if.empty;

  // Even slots land on even entries, odd slots on odd entries
  for (genvar k = 0; k < bank_depth; k++) begin : g_window
    assign entry[2*k]         = even_if.slot[k];
    assign entry[2*k+1]       = odd_if.slot[k];
    assign entry_valid[2*k]   = even_if.valid[k];
    assign entry_valid[2*k+1] = odd_if.valid[k];
  end

  assign oldest_ptr = pop_swap ? {odd_if.rd_ptr, 1'b1} : {even_if.rd_ptr, 1'b0};

endmodule

/* verilog/open_fifo_bank.sv */
`timescale 1ns/1ns

module open_fifo_bank
  import open_fifo_pkg::*;
#(
  parameter int data_width = 32
) (
  input logic            clk,
  input logic            arst_n,
  open_fifo_bank_if.bank bif
);

  logic [data_width-1:0]     mem [bank_depth];
  logic [bank_depth-1:0]     valid_q;
  logic [bank_depth-1:0]     valid_nxt;
  logic [bank_ptr_width-1:0] wr_ptr;
  logic [bank_ptr_width-1:0] rd_ptr;
  logic                      push_ok;
  logic                      pop_ok;
  logic                      full;
  logic                      empty;

  assign full  = &valid_q;
  assign empty = ~|valid_q;

  // Requests that would overrun the bank are dropped here
  assign push_ok = bif.push && !full;
  assign pop_ok  = bif.pop && !empty;

  always_comb begin
    valid_nxt = valid_q;
    if (push_ok) begin
      valid_nxt[wr_ptr] = 1'b1;
    end
    if (pop_ok) begin
      valid_nxt[rd_ptr] = 1'b0;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      valid_q <= '0;
    end else begin
      valid_q <= valid_nxt;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr <= '0;
    end else if (push_ok) begin
      if (wr_ptr == bank_ptr_width'(bank_depth - 1)) begin
        wr_ptr <= '0;
      end else begin
        wr_ptr <= wr_ptr + 1'b1;
      end
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      rd_ptr <= '0;
    end else if (pop_ok) begin
      if (rd_ptr == bank_ptr_width'(bank_depth - 1)) begin
        rd_ptr <= '0;
      end else begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

  // Storage
  always_ff @(posedge clk) begin
    if (push_ok) begin
      mem[wr_ptr] <= bif.in_data;
    end
  end

  assign bif.out_data = mem[rd_ptr];
  assign bif.full     = full;
  assign bif.empty    = empty;
  assign bif.slot     = mem;
  assign bif.valid    = valid_q;
  assign bif.rd_ptr   = rd_ptr;

endmodule

/* verilog/open_fifo_bank_if.sv */
`timescale 1ns/1ns

interface open_fifo_bank_if
  import open_fifo_pkg::*;
#(
  parameter int data_width = 32
) ();

  // Write and read strobes toward the bank
  logic                      push;
  logic [data_width-1:0]     in_data;
  logic                      pop;

  // Head entry and status back from the bank
  logic [data_width-1:0]     out_data;
  logic                      full;
  logic                      empty;

  // Open window onto every slot
  logic [data_width-1:0]     slot [bank_depth];
  logic [bank_depth-1:0]     valid;
  logic [bank_ptr_width-1:0] rd_ptr;

  modport ctrl (
    output push, in_data, pop,
    input  out_data, full, empty, slot, valid, rd_ptr
  );

  modport bank (
    input  push, in_data, pop,
    output out_data, full, empty, slot, valid, rd_ptr
  );

endinterface

/* verilog/open_fifo_pkg.sv */
package open_fifo_pkg;

  // Bank geometry
  localparam int bank_depth = 4;
  localparam int bank_ptr_width = 2;

  // Whole FIFO, two banks interleaved
  localparam int fifo_depth = 2 * bank_depth;
  localparam int fifo_ptr_width = bank_ptr_width + 1;

  // Request pair, encoded as {port1, port0}
  typedef enum logic [1:0] {
    REQ_NONE  = 2'b00,
    REQ_PORT0 = 2'b01,
    REQ_BAD   = 2'b10,
    REQ_BOTH  = 2'b11
  } port_req_e;

  function automatic port_req_e to_req(input logic p0, input logic p1);
    port_req_e req;
    req = port_req_e'({p1, p0});
    return req;
  endfunction

endpackage

/* verilog/open_fifo_top.sv */
`timescale 1ns/1ns

module open_fifo_top
  import open_fifo_pkg::*;
#(
  parameter int data_width = 32
) (
  input  logic                      clk,
  input  logic                      arst_n,
  // Write side
  input  logic                      push0,
  input  logic [data_width-1:0]     in_data0,
  input  logic                      push1,
  input  logic [data_width-1:0]     in_data1,
  // Read side
  input  logic                      pop0,
  input  logic                      pop1,
  output logic [data_width-1:0]     out_data0,
  output logic [data_width-1:0]     out_data1,
  // Status
  output logic                      full,
  output logic                      one_left_to_full,
  output logic                      empty,
  output logic                      one_left_to_empty,
  // Window
  output logic [data_width-1:0]     entry [fifo_depth],
  output logic [fifo_depth-1:0]     entry_valid,
  output logic [fifo_ptr_width-1:0] oldest_ptr
);

  open_fifo_2w2r #(.data_width(data_width)) u_fifo (
    .clk              (clk),
    .arst_n           (arst_n),
    .push0            (push0),
    .in_data0         (in_data0),
    .push1            (push1),
    .in_data1         (in_data1),
    .pop0             (pop0),
    .pop1             (pop1),
    .out_data0        (out_data0),
    .out_data1        (out_data1),
    .full             (full),
    .one_left_to_full (one_left_to_full),
    .empty            (empty),
    .one_left_to_empty(one_left_to_empty),
    .entry            (entry),
    .entry_valid      (entry_valid),
    .oldest_ptr       (oldest_ptr)
  );

endmodule
